// File: src/mul_cfg.svh
`ifndef MUL_CFG_SVH
`define MUL_CFG_SVH

// operand and result width of the RV32 datapath
`define MUL_XLEN 32

// physical register tag width
`define MUL_PREG_WIDTH 6

// ROB slot bits without the wrap flag
`define MUL_ROB_WIDTH 5

// the full ROB index is MUL_ROB_WIDTH + 1 bits
// the extra top bit flips on every pass around the ROB

// multiplier rows come out as MUL_XLEN / 2 + 1 Booth rows
// each row is twice the extended operand width

`endif

// File: src/mul_op_pkg.sv
`include "mul_cfg.svh"

package mul_op_pkg;

    // opcode of the multiply/divide group
    // bit 2 set means a divide, which this unit drops
    typedef enum logic [2:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHSU = 3'd2,
        MULHU  = 3'd3,
        DIV    = 3'd4,
        DIVU   = 3'd5,
        REM    = 3'd6,
        REMU   = 3'd7
    } multop_t;

    // operand or result
    typedef logic [`MUL_XLEN-1:0] xlen_t;

    // operand with two bits of sign or zero extension
    typedef logic [`MUL_XLEN+1:0] ext_op_t;

    // partial product and tree row, twice the extended operand
    typedef logic [2*`MUL_XLEN+3:0] prod_t;

endpackage

// File: src/backend_pkg.sv
`include "mul_cfg.svh"

package backend_pkg;

    // physical register tag
    typedef logic [`MUL_PREG_WIDTH-1:0] preg_t;

    // ROB index
    // top bit is the wrap flag, the rest is the slot
    typedef logic [`MUL_ROB_WIDTH:0] rob_idx_t;

    // slot part only
    typedef logic [`MUL_ROB_WIDTH-1:0] rob_slot_t;

    // two indices with the same wrap flag compare by slot directly
    // a differing flag means one of them has wrapped

endpackage

// File: src/booth_pp_gen.sv
`timescale 1ns/1ps

`include "mul_cfg.svh"

module booth_pp_gen (
    input  mul_op_pkg::ext_op_t  multiplicand,
    input  mul_op_pkg::ext_op_t  multiplier,
    output mul_op_pkg::prod_t    pp_rows [`MUL_XLEN/2+1],
    output logic [`MUL_XLEN/2:0] neg
);

    localparam int OP_W   = $bits(mul_op_pkg::ext_op_t);
    localparam int PROD_W = $bits(mul_op_pkg::prod_t);
    localparam int ROWS   = `MUL_XLEN / 2 + 1;

    mul_op_pkg::ext_op_t mcand_x2;
    logic [ROWS-1:0]     one_x;
    logic [ROWS-1:0]     two_x;

    // doubled multiplicand
    // the top bit is a copy of the one below, so nothing is lost
    assign mcand_x2 = {multiplicand[OP_W-2:0], 1'b0};

    for (genvar i = 0; i < ROWS; i++) begin : g_row
        logic [2:0]          triple;
        mul_op_pkg::ext_op_t sel;
        mul_op_pkg::prod_t   sext;
        mul_op_pkg::prod_t   fill;

        // overlapping multiplier triple, implicit zero below bit 0
        if (i == 0) begin : g_lsb
            assign triple = {multiplier[1:0], 1'b0};
        end else begin : g_upper
            assign triple = multiplier[2*i+1 -: 3];
        end

        // digit encode
        assign one_x[i] = triple[0] ^ triple[1];
        assign two_x[i] = (triple[2] & ~triple[1] & ~triple[0]) |
                          (~triple[2] & triple[1] & triple[0]);
        assign neg[i]   = triple[2] & ~(triple[1] & triple[0]);

        // select 0, x or 2x, ones complement when negative
        assign sel = {OP_W{neg[i]}} ^
                     (({OP_W{one_x[i]}} & multiplicand) |
                      ({OP_W{two_x[i]}} & mcand_x2));

        assign sext = {{(PROD_W-OP_W){sel[OP_W-1]}}, sel};

        // ones below the row on a negative digit
        // together with neg at bit 0 this completes the twos complement
        assign fill = {PROD_W{neg[i]}} & ~({PROD_W{1'b1}} << (2 * i));

        assign pp_rows[i] = (sext << (2 * i)) | fill;
    end

endmodule

// File: src/wallace_tree.sv
`timescale 1ns/1ps

`include "mul_cfg.svh"

module wallace_tree (
    input  logic                 clk,
    input  mul_op_pkg::prod_t    pp_rows [`MUL_XLEN/2+1],
    input  logic [`MUL_XLEN/2:0] neg,
    output mul_op_pkg::prod_t    sum_row,
    output mul_op_pkg::prod_t    carry_row,
    output logic                 carry_in
);

    localparam int PROD_W = $bits(mul_op_pkg::prod_t);

    // rows left after each level, 17 12 8 6 4 3 2
    localparam int N0 = `MUL_XLEN / 2 + 1;
    localparam int N1 = (N0 / 3) * 2 + N0 % 3;
    localparam int N2 = (N1 / 3) * 2 + N1 % 3;
    localparam int N3 = (N2 / 3) * 2 + N2 % 3;
    localparam int N4 = (N3 / 3) * 2 + N3 % 3;
    localparam int N5 = (N4 / 3) * 2 + N4 % 3;

    // first correction bit consumed by each level
    localparam int B1 = 0;
    localparam int B2 = B1 + N0 / 3;
    localparam int B3 = B2 + N1 / 3;
    localparam int B4 = B3 + N2 / 3;
    localparam int B5 = B4 + N3 / 3;
    localparam int B6 = B5 + N4 / 3;
    localparam int B7 = B6 + N5 / 3;

    typedef mul_op_pkg::prod_t row_arr_t [N0];

    // one level of 3:2 compression
    // rows out: sums, then pass-through rows, then carries
    function automatic row_arr_t reduce(
        input row_arr_t        rows,
        input int              n,
        input logic [N0-1:0]   corr,
        input int              base
    );
        row_arr_t          res;
        mul_op_pkg::prod_t maj;
        int                groups;
        int                left;

        groups = n / 3;
        left   = n % 3;
        res    = '{default: '0};
        for (int i = 0; i < N0 / 3; i++) begin
            if (i < groups) begin
                maj    = (rows[3*i] & rows[3*i+1]) |
                         (rows[3*i] & rows[3*i+2]) |
                         (rows[3*i+1] & rows[3*i+2]);
                res[i] = rows[3*i] ^ rows[3*i+1] ^ rows[3*i+2];
                // carry moves up one bit, the freed bit 0 takes a correction
                res[groups+left+i] = {maj[PROD_W-2:0], corr[base+i]};
            end
        end
        for (int i = 0; i < 2; i++) begin
            if (i < left) begin
                res[groups+i] = rows[3*groups+i];
            end
        end
        return res;
    endfunction

    row_arr_t          lv1;
    row_arr_t          lv2;
    row_arr_t          lv2_q;
    row_arr_t          lv3;
    row_arr_t          lv4;
    row_arr_t          lv5;
    row_arr_t          lv5_q;
    row_arr_t          lv6;
    logic [N0-1:B3]    corr_q1;
    logic [N0-1:B6]    corr_q2;

    // levels 1 and 2 in the issue cycle
    always_comb begin
        lv1 = reduce(pp_rows, N0, neg, B1);
        lv2 = reduce(lv1, N1, neg, B2);
    end

    always_ff @(posedge clk) begin
        lv2_q   <= lv2;
        corr_q1 <= neg[N0-1:B3];
    end

    // levels 3 to 5
    always_comb begin
        lv3 = reduce(lv2_q, N2, {corr_q1, {B3{1'b0}}}, B3);
        lv4 = reduce(lv3, N3, {corr_q1, {B3{1'b0}}}, B4);
        lv5 = reduce(lv4, N4, {corr_q1, {B3{1'b0}}}, B5);
    end

    always_ff @(posedge clk) begin
        lv5_q   <= lv5;
        corr_q2 <= corr_q1[N0-1:B6];
    end

    // last level feeds the final adder
    always_comb begin
        lv6 = reduce(lv5_q, N5, {corr_q2, {B6{1'b0}}}, B6);
    end

    assign sum_row   = lv6[0];
    assign carry_row = lv6[1];

    // two corrections remain for one carry-in
    // the top Booth row never negates since the multiplier has two extension bits
    assign carry_in = corr_q2[B7] | corr_q2[N0-1];

endmodule

// File: src/rob_age_compare.sv
`timescale 1ns/1ps

`include "mul_cfg.svh"

module rob_age_compare (
    input  backend_pkg::rob_idx_t idx,
    input  backend_pkg::rob_idx_t ref_idx,
    output logic                  older
);

    logic                   same_wrap;
    backend_pkg::rob_slot_t slot;
    backend_pkg::rob_slot_t ref_slot;

    assign same_wrap = idx[`MUL_ROB_WIDTH] == ref_idx[`MUL_ROB_WIDTH];
    assign slot      = idx[`MUL_ROB_WIDTH-1:0];
    assign ref_slot  = ref_idx[`MUL_ROB_WIDTH-1:0];

    // after a wrap the older entry has the larger slot
    assign older = same_wrap ? (slot < ref_slot) : (slot > ref_slot);

endmodule

// File: src/mult_unit.sv
`timescale 1ns/1ps

`include "mul_cfg.svh"

module mult_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    input  mul_op_pkg::multop_t   multop,
    input  mul_op_pkg::xlen_t     rs1_data,
    input  mul_op_pkg::xlen_t     rs2_data,
    input  backend_pkg::preg_t    rd,
    input  logic                  we,
    input  backend_pkg::rob_idx_t rob_idx,
    input  logic                  redirect,
    input  backend_pkg::rob_idx_t redirect_idx,
    output logic                  wakeup_en,
    output logic                  wakeup_we,
    output backend_pkg::preg_t    wakeup_rd,
    output logic                  wb_en,
    output logic                  wb_we,
    output backend_pkg::preg_t    wb_rd,
    output backend_pkg::rob_idx_t wb_rob_idx,
    output mul_op_pkg::xlen_t     wb_res
);

    localparam int XLEN = `MUL_XLEN;
    localparam int ROWS = `MUL_XLEN / 2 + 1;

    logic                  signed_a;
    logic                  signed_b;
    logic                  sel_hi;
    logic                  valid_s0;
    mul_op_pkg::ext_op_t   op_a;
    mul_op_pkg::ext_op_t   op_b;
    mul_op_pkg::prod_t     pp_rows [ROWS];
    logic [ROWS-1:0]       neg;
    mul_op_pkg::prod_t     sum_row;
    mul_op_pkg::prod_t     carry_row;
    logic                  carry_in;
    mul_op_pkg::prod_t     product;

    logic                  older_s0;
    logic                  older_s1;
    logic                  older_s2;
    logic                  valid_s1;
    logic                  valid_s2;
    logic                  sel_hi_s1;
    logic                  sel_hi_s2;
    logic                  we_s1;
    logic                  we_s2;
    backend_pkg::preg_t    rd_s1;
    backend_pkg::preg_t    rd_s2;
    backend_pkg::rob_idx_t rob_idx_s1;
    backend_pkg::rob_idx_t rob_idx_s2;

    // operand signedness and result half
    always_comb begin
        signed_a = 1'b0;
        signed_b = 1'b0;
        sel_hi   = 1'b0;
        case (multop)
            mul_op_pkg::MUL: begin
                signed_a = 1'b1;
                signed_b = 1'b1;
            end
            mul_op_pkg::MULH: begin
                signed_a = 1'b1;
                signed_b = 1'b1;
                sel_hi   = 1'b1;
            end
            mul_op_pkg::MULHSU: begin
                signed_a = 1'b1;
                sel_hi   = 1'b1;
            end
            mul_op_pkg::MULHU: begin
                sel_hi = 1'b1;
            end
            default: begin
                sel_hi = 1'b0;
            end
        endcase
    end

    assign op_a = {{2{signed_a & rs1_data[XLEN-1]}}, rs1_data};
    assign op_b = {{2{signed_b & rs2_data[XLEN-1]}}, rs2_data};

    // divides never wake up a consumer here
    assign valid_s0  = en & ~multop[2];
    assign wakeup_en = valid_s0;
    assign wakeup_we = we;
    assign wakeup_rd = rd;

    booth_pp_gen booth_pp_gen_i (
        .multiplicand (op_a),
        .multiplier   (op_b),
        .pp_rows      (pp_rows),
        .neg          (neg)
    );

    wallace_tree wallace_tree_i (
        .clk       (clk),
        .pp_rows   (pp_rows),
        .neg       (neg),
        .sum_row   (sum_row),
        .carry_row (carry_row),
        .carry_in  (carry_in)
    );

    // one age check per kill point
    rob_age_compare age_s0_i (
        .idx     (rob_idx),
        .ref_idx (redirect_idx),
        .older   (older_s0)
    );

    rob_age_compare age_s1_i (
        .idx     (rob_idx_s1),
        .ref_idx (redirect_idx),
        .older   (older_s1)
    );

    rob_age_compare age_s2_i (
        .idx     (rob_idx_s2),
        .ref_idx (redirect_idx),
        .older   (older_s2)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
        end else begin
            valid_s1 <= valid_s0 & (~redirect | older_s0);
            valid_s2 <= valid_s1 & (~redirect | older_s1);
        end
    end

    // tags travel beside the tree
    always_ff @(posedge clk) begin
        sel_hi_s1  <= sel_hi;
        we_s1      <= we;
        rd_s1      <= rd;
        rob_idx_s1 <= rob_idx;
        sel_hi_s2  <= sel_hi_s1;
        we_s2      <= we_s1;
        rd_s2      <= rd_s1;
        rob_idx_s2 <= rob_idx_s1;
    end

    // final carry-propagate add
    assign product = sum_row + carry_row + mul_op_pkg::prod_t'(carry_in);

    assign wb_en      = valid_s2 & (~redirect | older_s2);
    assign wb_we      = we_s2;
    assign wb_rd      = rd_s2;
    assign wb_rob_idx = rob_idx_s2;
    assign wb_res     = sel_hi_s2 ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];

endmodule

// File: testbench/mult_unit_assert.sv
`timescale 1ns/1ps

module mult_unit_assert (
    input logic              clk,
    input logic              rst_n,
    input logic              en,
    input logic              wakeup_en,
    input logic              wb_en,
    input mul_op_pkg::xlen_t wb_res
);

    // a wakeup only comes with an issue
    a_wakeup_needs_en: assert property (
        @(posedge clk) disable iff (!rst_n) wakeup_en |-> en
    ) else $error("wakeup_en high while en is low");

    // fixed two-cycle latency from wakeup to writeback
    a_wb_latency: assert property (
        @(posedge clk) disable iff (!rst_n) wb_en |-> $past(wakeup_en, 2)
    ) else $error("wb_en without a wakeup two cycles earlier");

    a_wb_low_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> !wb_en
    ) else $error("wb_en high in the first cycle after reset");

    a_wb_res_known: assert property (
        @(posedge clk) disable iff (!rst_n) wb_en |-> !$isunknown(wb_res)
    ) else $error("wb_res has unknown bits during a writeback");

endmodule

bind mult_unit mult_unit_assert mult_unit_assert_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (en),
    .wakeup_en (wakeup_en),
    .wb_en     (wb_en),
    .wb_res    (wb_res)
);

// File: testbench/mult_unit_tb.sv
`timescale 1ns/1ps

module mult_unit_tb;

    localparam int          MAX_ROWS  = 320;
    localparam int          RAND_ROWS = 200;
    localparam int          SLOT_W    = $bits(backend_pkg::rob_idx_t) - 1;
    localparam logic [31:0] LFSR_SEED = 32'h9949_8886;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    typedef struct packed {
        logic                  en;
        logic [2:0]            op;
        mul_op_pkg::xlen_t     a;
        mul_op_pkg::xlen_t     b;
        backend_pkg::preg_t    rd;
        logic                  we;
        backend_pkg::rob_idx_t rob;
        logic                  redirect;
        backend_pkg::rob_idx_t redirect_idx;
    } stim_t;

    typedef struct packed {
        int                    cycle;
        backend_pkg::preg_t    rd;
        logic                  we;
        backend_pkg::rob_idx_t rob;
        mul_op_pkg::xlen_t     res;
    } wb_exp_t;

    logic                  clk;
    logic                  rst_n;
    logic                  en;
    mul_op_pkg::multop_t   multop;
    mul_op_pkg::xlen_t     rs1_data;
    mul_op_pkg::xlen_t     rs2_data;
    backend_pkg::preg_t    rd;
    logic                  we;
    backend_pkg::rob_idx_t rob_idx;
    logic                  redirect;
    backend_pkg::rob_idx_t redirect_idx;
    logic                  wakeup_en;
    logic                  wakeup_we;
    backend_pkg::preg_t    wakeup_rd;
    logic                  wb_en;
    logic                  wb_we;
    backend_pkg::preg_t    wb_rd;
    backend_pkg::rob_idx_t wb_rob_idx;
    mul_op_pkg::xlen_t     wb_res;

    stim_t       stim [MAX_ROWS];
    stim_t       cur;
    wb_exp_t     exp_q [$];
    int          num_rows;
    logic [31:0] lfsr_state;
    int          mismatch_count = 0;
    int          event_count = 0;
    int          cycle_count = 0;
    int          timeout_limit = MAX_ROWS + 20;

    mult_unit mult_unit_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .multop       (multop),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rd           (rd),
        .we           (we),
        .rob_idx      (rob_idx),
        .redirect     (redirect),
        .redirect_idx (redirect_idx),
        .wakeup_en    (wakeup_en),
        .wakeup_we    (wakeup_we),
        .wakeup_rd    (wakeup_rd),
        .wb_en        (wb_en),
        .wb_we        (wb_we),
        .wb_rd        (wb_rd),
        .wb_rob_idx   (wb_rob_idx),
        .wb_res       (wb_res)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count > timeout_limit) begin
                $display("timeout after %0d cycles, the run did not finish", cycle_count);
                $display("TEST FAIL");
                $finish;
            end
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] next;
        next = s >> 1;
        if (s[0]) begin
            next = next ^ LFSR_TAPS;
        end
        return next;
    endfunction

    // one LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // strictly older, with the wrap flag on top
    function automatic logic is_older(input backend_pkg::rob_idx_t idx,
                                      input backend_pkg::rob_idx_t ref_idx);
        if (idx[SLOT_W] == ref_idx[SLOT_W]) begin
            return idx[SLOT_W-1:0] < ref_idx[SLOT_W-1:0];
        end
        return idx[SLOT_W-1:0] > ref_idx[SLOT_W-1:0];
    endfunction

    // 64-bit product of the sign or zero extended operands
    function automatic mul_op_pkg::xlen_t model_result(input logic [2:0] op,
                                                       input mul_op_pkg::xlen_t a,
                                                       input mul_op_pkg::xlen_t b);
        logic [63:0] wide_a;
        logic [63:0] wide_b;
        logic [63:0] prod;
        wide_a = (op <= 3'd2) ? {{32{a[31]}}, a} : {32'h0, a};
        wide_b = (op <= 3'd1) ? {{32{b[31]}}, b} : {32'h0, b};
        prod   = wide_a * wide_b;
        if (op == 3'd0) begin
            return prod[31:0];
        end
        return prod[63:32];
    endfunction

    task automatic add_row(input logic e, input logic [2:0] op, input mul_op_pkg::xlen_t a,
                           input mul_op_pkg::xlen_t b, input backend_pkg::rob_idx_t rob,
                           input logic redir, input backend_pkg::rob_idx_t ridx);
        stim_t row;
        row.en           = e;
        row.op           = op;
        row.a            = a;
        row.b            = b;
        row.rd           = backend_pkg::preg_t'(num_rows) ^ 6'h2a;
        row.we           = (num_rows % 5) != 4;
        row.rob          = rob;
        row.redirect     = redir;
        row.redirect_idx = ridx;
        stim[num_rows]   = row;
        num_rows++;
    endtask

    task automatic build_directed();
        mul_op_pkg::xlen_t     corner [5];
        backend_pkg::rob_idx_t rob;
        corner = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        rob    = 6'h01;
        // idle after reset
        for (int i = 0; i < 3; i++) begin
            add_row(1'b0, 3'd0, '0, '0, '0, 1'b0, '0);
        end
        // operand corners for every multiply, issued back to back
        for (int op = 0; op < 4; op++) begin
            for (int k = 0; k < 5; k++) begin
                add_row(1'b1, 3'(op), corner[k], corner[k], rob, 1'b0, '0);
                add_row(1'b1, 3'(op), corner[k], corner[4-k], rob + 6'd1, 1'b0, '0);
                rob = rob + 6'd2;
            end
        end
        // divides and a row without en
        add_row(1'b1, 3'd4, 32'h0000_0064, 32'h0000_0007, 6'h10, 1'b0, '0);
        add_row(1'b1, 3'd7, 32'h8000_0000, 32'hffff_ffff, 6'h11, 1'b0, '0);
        add_row(1'b0, 3'd0, 32'h0000_0003, 32'h0000_0005, 6'h12, 1'b0, '0);
        // kill at issue, older one in the same redirect cycle
        add_row(1'b1, 3'd0, 32'h0000_1234, 32'h0000_0011, 6'h22, 1'b1, 6'h21);
        add_row(1'b1, 3'd1, 32'h8000_0000, 32'h0000_0003, 6'h20, 1'b1, 6'h21);
        // kill in stage 1 on an equal index
        add_row(1'b1, 3'd2, 32'hdead_beef, 32'h0bad_f00d, 6'h23, 1'b0, '0);
        add_row(1'b0, 3'd0, '0, '0, '0, 1'b1, 6'h23);
        // redirect across the wrap hits all three stages
        add_row(1'b1, 3'd1, 32'h1234_5678, 32'h8765_4321, 6'h1a, 1'b0, '0);
        add_row(1'b1, 3'd3, 32'hffff_0000, 32'h0001_ffff, 6'h1f, 1'b0, '0);
        add_row(1'b1, 3'd0, 32'h0000_0007, 32'h0000_0009, 6'h20, 1'b1, 6'h1c);
        // kill at writeback
        add_row(1'b1, 3'd2, 32'hffff_fffe, 32'h0000_0005, 6'h1e, 1'b0, '0);
        add_row(1'b0, 3'd0, '0, '0, '0, 1'b0, '0);
        add_row(1'b0, 3'd0, '0, '0, '0, 1'b1, 6'h1d);
        // older before the wrap survives, younger after it dies
        add_row(1'b1, 3'd3, 32'hcafe_babe, 32'h1357_9bdf, 6'h3e, 1'b0, '0);
        add_row(1'b1, 3'd1, 32'h8000_0001, 32'h7fff_ffff, 6'h01, 1'b0, '0);
        add_row(1'b0, 3'd0, '0, '0, '0, 1'b1, 6'h00);
        add_row(1'b0, 3'd0, '0, '0, '0, 1'b0, '0);
    endtask

    task automatic fill_random_rows();
        logic [31:0]           r_en;
        logic [31:0]           r_op;
        logic [31:0]           r_a;
        logic [31:0]           r_b;
        logic [31:0]           r_redir;
        logic [31:0]           r_back;
        backend_pkg::rob_idx_t rob_ctr;
        rob_ctr = 6'h08;
        for (int i = 0; i < RAND_ROWS; i++) begin
            take_bits(2, r_en);
            take_bits(3, r_op);
            take_bits(32, r_a);
            take_bits(32, r_b);
            take_bits(4, r_redir);
            take_bits(2, r_back);
            // redirect points a few entries back from the newest
            add_row(r_en[1:0] != 2'b00, r_op[2:0], r_a, r_b, rob_ctr, r_redir[3:0] == 4'h0,
                    rob_ctr - backend_pkg::rob_idx_t'(r_back[1:0]));
            if (r_en[1:0] != 2'b00) begin
                rob_ctr = rob_ctr + 6'd1;
            end
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic apply_row(input int c);
        wb_exp_t entry;
        if (c < num_rows) begin
            cur = stim[c];
        end else begin
            cur = '0;
        end
        en           = cur.en;
        multop       = mul_op_pkg::multop_t'(cur.op);
        rs1_data     = cur.a;
        rs2_data     = cur.b;
        rd           = cur.rd;
        we           = cur.we;
        rob_idx      = cur.rob;
        redirect     = cur.redirect;
        redirect_idx = cur.redirect_idx;
        if (cur.en && !cur.op[2]) begin
            entry.cycle = c;
            entry.rd    = cur.rd;
            entry.we    = cur.we;
            entry.rob   = cur.rob;
            entry.res   = model_result(cur.op, cur.a, cur.b);
            exp_q.push_back(entry);
        end
    endtask

    task automatic check_cycle(input int c);
        wb_exp_t head;
        logic    wake_exp;
        wake_exp = cur.en & ~cur.op[2];
        check_value("wakeup_en", 64'(wake_exp), 64'(wakeup_en));
        check_value("wakeup_we", 64'(cur.we), 64'(wakeup_we));
        check_value("wakeup_rd", 64'(cur.rd), 64'(wakeup_rd));
        // a redirect drops every in-flight entry that is not strictly older
        if (cur.redirect) begin
            for (int i = exp_q.size() - 1; i >= 0; i--) begin
                if (!is_older(exp_q[i].rob, cur.redirect_idx)) begin
                    exp_q.delete(i);
                end
            end
        end
        if (exp_q.size() > 0 && exp_q[0].cycle == c - 2) begin
            head = exp_q.pop_front();
            if (wb_en !== 1'b1) begin
                event_count++;
                $display("at %0t no writeback came for rob index %h issued in cycle %0d",
                         $time, head.rob, head.cycle);
            end else begin
                check_value("wb_we", 64'(head.we), 64'(wb_we));
                check_value("wb_rd", 64'(head.rd), 64'(wb_rd));
                check_value("wb_rob_idx", 64'(head.rob), 64'(wb_rob_idx));
                check_value("wb_res", 64'(head.res), 64'(wb_res));
            end
        end else if (wb_en !== 1'b0) begin
            event_count++;
            $display("at %0t a writeback came when none was due, wb_en %b rob index %h",
                     $time, wb_en, wb_rob_idx);
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        en           = 1'b0;
        multop       = mul_op_pkg::MUL;
        rs1_data     = '0;
        rs2_data     = '0;
        rd           = '0;
        we           = 1'b0;
        rob_idx      = '0;
        redirect     = 1'b0;
        redirect_idx = '0;
        cur          = '0;
        lfsr_state   = LFSR_SEED;
        num_rows     = 0;
        build_directed();
        fill_random_rows();
        timeout_limit = num_rows + 20;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // three extra cycles drain the pipeline
        for (int c = 0; c < num_rows + 3; c++) begin
            @(posedge clk);
            #2;
            apply_row(c);
            @(negedge clk);
            check_cycle(c);
        end
        if (exp_q.size() != 0) begin
            event_count += exp_q.size();
            $display("%0d expected writebacks never arrived", exp_q.size());
        end
        $display("errors: %0d value mismatches, %0d missing or unexpected writebacks",
                 mismatch_count, event_count);
        if (mismatch_count == 0 && event_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+src
src/mul_op_pkg.sv
src/backend_pkg.sv
src/booth_pp_gen.sv
src/wallace_tree.sv
src/rob_age_compare.sv
src/mult_unit.sv
testbench/mult_unit_assert.sv
testbench/mult_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module mult_unit_tb -o mult_unit_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/mult_unit_sim > sim.log 2>&1
grep -qx "TEST PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
